// ==== include/oq_macros.svh ====
`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

//////////////////////////////
// packet word format
//////////////////////////////

`define OQ_DATA_WIDTH 64
// one keep bit per data byte
`define OQ_KEEP_WIDTH 8

//////////////////////////////
// buffer and calendar sizing
//////////////////////////////

`define OQ_BUF_DEPTH 64
`define OQ_ADDR_WIDTH 6
`define OQ_RANK_WIDTH 10
// rank in the upper bits, start address in the lower bits
`define OQ_PIFO_WIDTH 16
`define OQ_PIFO_DEPTH 16

// largest packet (8 words) plus the reserve word, with some slack
`define OQ_ALMOST_FULL_MARGIN 12

`endif

// ==== src/oq_pkg.sv ====
`include "oq_macros.svh"

package oq_pkg;

    // word address inside the packet buffer
    typedef logic [`OQ_ADDR_WIDTH-1:0] buf_addr_t;

    // scheduling rank, smaller leaves earlier
    typedef logic [`OQ_RANK_WIDTH-1:0] rank_t;

    //////////////////////////////
    // scheduling word
    //////////////////////////////

    // ports carry it as a raw word
    // the calendar reads rank and start address out of it
    typedef union packed
    {
        logic [`OQ_PIFO_WIDTH-1:0] raw;
        struct packed
        {
            rank_t     rank;
            buf_addr_t addr;
        } fld;
    } pifo_word_t;

endpackage

// ==== src/pkt_store.sv ====
`include "oq_macros.svh"

module pkt_store
    import oq_pkg::*;
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,
    input  logic                       s_axis_tvalid,
    input  logic                       s_axis_buffer_wr_en,
    input  logic [`OQ_DATA_WIDTH-1:0]  s_axis_tdata,
    input  logic [`OQ_KEEP_WIDTH-1:0]  s_axis_tkeep,
    input  logic                       s_axis_tlast,
    input  buf_addr_t                  rd_addr,
    input  logic                       rd_free,
    output logic [`OQ_DATA_WIDTH-1:0]  rd_word,
    output logic [`OQ_KEEP_WIDTH-1:0]  rd_keep,
    output logic                       rd_last,
    output buf_addr_t                  next_addr,
    output logic                       pkt_done,
    output buf_addr_t                  pkt_sop,
    output logic [`OQ_ADDR_WIDTH:0]    m_buffer_counter,
    output logic                       m_is_buffer_almost_full
);

    logic [`OQ_DATA_WIDTH-1:0] mem_data [`OQ_BUF_DEPTH];
    logic [`OQ_KEEP_WIDTH-1:0] mem_keep [`OQ_BUF_DEPTH];
    logic                      mem_last [`OQ_BUF_DEPTH];
    buf_addr_t                 link     [`OQ_BUF_DEPTH];

    buf_addr_t                 fl_head;
    buf_addr_t                 fl_tail;
    buf_addr_t                 sop_q;
    logic                      in_pkt;
    logic                      wr_en;
    buf_addr_t                 rd_addr_q;
    buf_addr_t                 out_addr;
    logic [`OQ_ADDR_WIDTH:0]   count_nxt;

    assign wr_en    = s_axis_tvalid & s_axis_buffer_wr_en;
    assign pkt_done = wr_en & s_axis_tlast;
    // single word packets start at the current head
    assign pkt_sop  = in_pkt ? sop_q : fl_head;

    //////////////////////////////
    // word memory
    //////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem_data[fl_head] <= s_axis_tdata;
            mem_keep[fl_head] <= s_axis_tkeep;
            mem_last[fl_head] <= s_axis_tlast;
        end
        // synchronous read, a held address is simply read again
        rd_word   <= mem_data[rd_addr];
        rd_keep   <= mem_keep[rd_addr];
        rd_last   <= mem_last[rd_addr];
        next_addr <= link[rd_addr];
    end

    //////////////////////////////
    // free list and link table
    //////////////////////////////

    // words are taken in free-list order, so a packet's chain is
    // already in the link table and only the tail is ever rewritten
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int i = 0; i < `OQ_BUF_DEPTH; i++)
            begin
                link[i] <= buf_addr_t'((i + 1) % `OQ_BUF_DEPTH);
            end
            fl_head <= '0;
            fl_tail <= buf_addr_t'(`OQ_BUF_DEPTH - 1);
        end
        else
        begin
            if (wr_en)
            begin
                fl_head <= link[fl_head];
            end
            if (rd_free)
            begin
                link[fl_tail] <= out_addr;
                fl_tail       <= out_addr;
            end
        end
    end

    // rd_addr only moves away from the word in rd_word when that word
    // is loaded into the output register, so the left-behind address
    // is the one that will be freed on accept
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            rd_addr_q <= '0;
            out_addr  <= '0;
            in_pkt    <= 1'b0;
        end
        else
        begin
            rd_addr_q <= rd_addr;
            if (rd_addr != rd_addr_q)
            begin
                out_addr <= rd_addr_q;
            end
            if (wr_en)
            begin
                in_pkt <= !s_axis_tlast;
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en && !in_pkt)
        begin
            sop_q <= fl_head;
        end
    end

    //////////////////////////////
    // occupancy
    //////////////////////////////

    always_comb
    begin
        count_nxt = m_buffer_counter;
        if (wr_en && !rd_free)
        begin
            count_nxt = m_buffer_counter + 1'b1;
        end
        else if (!wr_en && rd_free)
        begin
            count_nxt = m_buffer_counter - 1'b1;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            m_buffer_counter        <= '0;
            m_is_buffer_almost_full <= 1'b0;
        end
        else
        begin
            m_buffer_counter        <= count_nxt;
            // free words below the margin
            m_is_buffer_almost_full <=
                (count_nxt > (`OQ_BUF_DEPTH - `OQ_ALMOST_FULL_MARGIN));
        end
    end

endmodule

// ==== src/pifo_calendar.sv ====
`include "oq_macros.svh"

module pifo_calendar
    import oq_pkg::*;
(
    input  logic       axis_aclk,
    input  logic       axis_resetn,
    input  logic       pkt_done,
    input  buf_addr_t  pkt_sop,
    input  pifo_word_t s_axis_tpifo,
    input  logic       pop_en,
    output pifo_word_t head_entry,
    output logic       empty,
    output logic       m_is_pifo_full
);

    localparam int CNT_W = $clog2(`OQ_PIFO_DEPTH + 1);

    pifo_word_t        entries      [`OQ_PIFO_DEPTH];
    pifo_word_t        shifted      [`OQ_PIFO_DEPTH];
    pifo_word_t        next_entries [`OQ_PIFO_DEPTH];
    pifo_word_t        new_entry;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  cnt_popped;
    logic [CNT_W-1:0]  ins_pos;

    assign head_entry     = entries[0];
    assign empty          = (count == '0);
    assign m_is_pifo_full = (count == CNT_W'(`OQ_PIFO_DEPTH));

    // address field of the incoming word is ignored
    always_comb
    begin
        new_entry.fld.rank = s_axis_tpifo.fld.rank;
        new_entry.fld.addr = pkt_sop;
    end

    //////////////////////////////
    // pop first, then insert
    //////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `OQ_PIFO_DEPTH - 1; i++)
        begin
            shifted[i] = pop_en ? entries[i + 1] : entries[i];
        end
        shifted[`OQ_PIFO_DEPTH - 1] = entries[`OQ_PIFO_DEPTH - 1];
        cnt_popped = pop_en ? count - 1'b1 : count;
    end

    // new entry goes behind every rank less or equal, ties keep arrival order
    always_comb
    begin
        ins_pos = '0;
        for (int i = 0; i < `OQ_PIFO_DEPTH; i++)
        begin
            if (i < cnt_popped && shifted[i].fld.rank <= new_entry.fld.rank)
            begin
                ins_pos = ins_pos + 1'b1;
            end
        end
    end

    always_comb
    begin
        next_entries[0] = (pkt_done && ins_pos == '0) ? new_entry : shifted[0];
        for (int i = 1; i < `OQ_PIFO_DEPTH; i++)
        begin
            if (!pkt_done || i < ins_pos)
            begin
                next_entries[i] = shifted[i];
            end
            else if (i == ins_pos)
            begin
                next_entries[i] = new_entry;
            end
            else
            begin
                next_entries[i] = shifted[i - 1];
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        for (int i = 0; i < `OQ_PIFO_DEPTH; i++)
        begin
            entries[i] <= next_entries[i];
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            count <= '0;
        end
        else
        begin
            count <= cnt_popped + CNT_W'(pkt_done);
        end
    end

endmodule

// ==== src/dequeue_ctrl.sv ====
`include "oq_macros.svh"

module dequeue_ctrl
    import oq_pkg::*;
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,
    input  pifo_word_t                 head_entry,
    input  logic                       empty,
    output logic                       pop_en,
    output buf_addr_t                  rd_addr,
    input  logic [`OQ_DATA_WIDTH-1:0]  rd_word,
    input  logic [`OQ_KEEP_WIDTH-1:0]  rd_keep,
    input  logic                       rd_last,
    input  buf_addr_t                  next_addr,
    output logic                       rd_free,
    input  logic                       m_axis_tready,
    output logic                       m_axis_tvalid,
    output logic [`OQ_DATA_WIDTH-1:0]  m_axis_tdata,
    output logic [`OQ_KEEP_WIDTH-1:0]  m_axis_tkeep,
    output logic                       m_axis_tlast,
    output pifo_word_t                 m_axis_tpifo
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_FIRST  = 2'd1;
    localparam logic [1:0] ST_STREAM = 2'd2;

    logic [1:0] state;
    buf_addr_t  rd_ptr;
    logic       accept;
    logic       load;

    assign accept  = m_axis_tvalid & m_axis_tready;
    assign rd_free = accept;
    assign pop_en  = (state == ST_IDLE) & !empty;

    // output register is empty in first read, and refills on accept
    // until the last word of the packet sits in it
    assign load = (state == ST_FIRST) ||
                  (state == ST_STREAM && accept && !m_axis_tlast);

    //////////////////////////////
    // read address
    //////////////////////////////

    always_comb
    begin
        if (state == ST_IDLE)
        begin
            rd_addr = head_entry.fld.addr;
        end
        else if (load)
        begin
            // fetch the word behind the one being loaded
            rd_addr = next_addr;
        end
        else
        begin
            rd_addr = rd_ptr;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state         <= ST_IDLE;
            rd_ptr        <= '0;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            rd_ptr <= rd_addr;
            case (state)
                ST_IDLE:
                begin
                    if (pop_en)
                    begin
                        state <= ST_FIRST;
                    end
                end
                ST_FIRST:
                begin
                    state <= ST_STREAM;
                end
                default:
                begin
                    if (accept && m_axis_tlast)
                    begin
                        state <= ST_IDLE;
                    end
                end
            endcase
            if (load)
            begin
                m_axis_tvalid <= 1'b1;
            end
            else if (accept)
            begin
                m_axis_tvalid <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // output payload
    //////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (load)
        begin
            m_axis_tdata <= rd_word;
            m_axis_tkeep <= rd_keep;
            m_axis_tlast <= rd_last;
        end
        // popped entry stays with the whole packet
        if (pop_en)
        begin
            m_axis_tpifo <= head_entry;
        end
    end

endmodule

// ==== src/output_queue.sv ====
`include "oq_macros.svh"

module output_queue
    import oq_pkg::*;
(
    input  logic                       axis_aclk,
    input  logic                       axis_resetn,

    // enqueue side
    input  logic                       s_axis_tvalid,
    input  logic [`OQ_DATA_WIDTH-1:0]  s_axis_tdata,
    input  logic [`OQ_KEEP_WIDTH-1:0]  s_axis_tkeep,
    input  logic                       s_axis_tlast,
    input  pifo_word_t                 s_axis_tpifo,
    input  logic                       s_axis_buffer_wr_en,

    // port side
    input  logic                       m_axis_tready,
    output logic                       m_axis_tvalid,
    output logic [`OQ_DATA_WIDTH-1:0]  m_axis_tdata,
    output logic [`OQ_KEEP_WIDTH-1:0]  m_axis_tkeep,
    output logic                       m_axis_tlast,
    output pifo_word_t                 m_axis_tpifo,

    // levels
    output logic                       m_is_buffer_almost_full,
    output logic                       m_is_pifo_full,
    output logic [`OQ_ADDR_WIDTH:0]    m_buffer_counter
);

    logic                      pkt_done;
    buf_addr_t                 pkt_sop;
    buf_addr_t                 rd_addr;
    logic                      rd_free;
    logic [`OQ_DATA_WIDTH-1:0] rd_word;
    logic [`OQ_KEEP_WIDTH-1:0] rd_keep;
    logic                      rd_last;
    buf_addr_t                 next_addr;
    pifo_word_t                head_entry;
    logic                      empty;
    logic                      pop_en;

    pkt_store pkt_store_inst (
        .axis_aclk               (axis_aclk),
        .axis_resetn             (axis_resetn),
        .s_axis_tvalid           (s_axis_tvalid),
        .s_axis_buffer_wr_en     (s_axis_buffer_wr_en),
        .s_axis_tdata            (s_axis_tdata),
        .s_axis_tkeep            (s_axis_tkeep),
        .s_axis_tlast            (s_axis_tlast),
        .rd_addr                 (rd_addr),
        .rd_free                 (rd_free),
        .rd_word                 (rd_word),
        .rd_keep                 (rd_keep),
        .rd_last                 (rd_last),
        .next_addr               (next_addr),
        .pkt_done                (pkt_done),
        .pkt_sop                 (pkt_sop),
        .m_buffer_counter        (m_buffer_counter),
        .m_is_buffer_almost_full (m_is_buffer_almost_full)
    );

    pifo_calendar pifo_calendar_inst (
        .axis_aclk      (axis_aclk),
        .axis_resetn    (axis_resetn),
        .pkt_done       (pkt_done),
        .pkt_sop        (pkt_sop),
        .s_axis_tpifo   (s_axis_tpifo),
        .pop_en         (pop_en),
        .head_entry     (head_entry),
        .empty          (empty),
        .m_is_pifo_full (m_is_pifo_full)
    );

    dequeue_ctrl dequeue_ctrl_inst (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .head_entry    (head_entry),
        .empty         (empty),
        .pop_en        (pop_en),
        .rd_addr       (rd_addr),
        .rd_word       (rd_word),
        .rd_keep       (rd_keep),
        .rd_last       (rd_last),
        .next_addr     (next_addr),
        .rd_free       (rd_free),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tpifo  (m_axis_tpifo)
    );

endmodule

// ==== verif/output_queue_properties.sv ====
`include "oq_macros.svh"

module output_queue_properties
    import oq_pkg::*;
(
    input logic                      axis_aclk,
    input logic                      axis_resetn,
    input logic                      m_axis_tvalid,
    input logic                      m_axis_tready,
    input logic [`OQ_DATA_WIDTH-1:0] m_axis_tdata,
    input logic [`OQ_KEEP_WIDTH-1:0] m_axis_tkeep,
    input logic                      m_axis_tlast,
    input pifo_word_t                m_axis_tpifo,
    input logic                      pop_en,
    input logic                      pkt_done,
    input logic                      m_is_pifo_full
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CNT_W = $clog2(`OQ_PIFO_DEPTH + 1);

    // packets inserted and not yet popped
    logic [CNT_W-1:0] queued;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            queued <= '0;
        end
        else
        begin
            queued <= queued + CNT_W'(pkt_done) - CNT_W'(pop_en);
        end
    end

    //////////////////////////////
    // output port
    //////////////////////////////

    // a stalled word stays put until taken
    property stall_hold;
        @(posedge axis_aclk) disable iff (!axis_resetn)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep)
            && $stable(m_axis_tlast) && $stable(m_axis_tpifo);
    endproperty

    assert property (stall_hold)
    else $error("output word changed while the port was stalled");

    //////////////////////////////
    // calendar use
    //////////////////////////////

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        pop_en |-> queued != '0)
    else $error("calendar popped while empty");

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn) pkt_done |-> !m_is_pifo_full)
    else $error("calendar insert while full");

endmodule

bind output_queue output_queue_properties output_queue_properties_inst (.*);

// ==== verif/output_queue_tb.sv ====
`include "oq_macros.svh"

module output_queue_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_PKTS       = 64;
    localparam int MAX_WORDS      = 8;
    // 40 packets of up to 8 words, ready low about half the time
    localparam int TIMEOUT_CYCLES = 40 * 8 * 4 + 2000;

    typedef int id_list_t[$];

    logic                      axis_aclk = 1'b0;
    logic                      axis_resetn;
    logic                      s_axis_tvalid;
    logic [`OQ_DATA_WIDTH-1:0] s_axis_tdata;
    logic [`OQ_KEEP_WIDTH-1:0] s_axis_tkeep;
    logic                      s_axis_tlast;
    logic [`OQ_PIFO_WIDTH-1:0] s_axis_tpifo;
    logic                      s_axis_buffer_wr_en;
    logic                      m_axis_tready;
    logic                      m_axis_tvalid;
    logic [`OQ_DATA_WIDTH-1:0] m_axis_tdata;
    logic [`OQ_KEEP_WIDTH-1:0] m_axis_tkeep;
    logic                      m_axis_tlast;
    logic [`OQ_PIFO_WIDTH-1:0] m_axis_tpifo;
    logic                      m_is_buffer_almost_full;
    logic                      m_is_pifo_full;
    logic [`OQ_ADDR_WIDTH:0]   m_buffer_counter;

    // packets as sent, by packet number
    logic [`OQ_DATA_WIDTH-1:0] pkt_data [MAX_PKTS][MAX_WORDS];
    logic [`OQ_KEEP_WIDTH-1:0] pkt_keep [MAX_PKTS][MAX_WORDS];
    int                        pkt_len  [MAX_PKTS];
    int                        pkt_rank [MAX_PKTS];

    id_list_t                  exp_order;
    id_list_t                  burst;
    int                        num_pkts    = 0;
    int                        pkts_out    = 0;
    int                        word_idx    = 0;
    int                        words_in    = 0;
    int                        words_out   = 0;
    int                        cycle_count = 0;
    bit                        run_over    = 1'b0;
    integer                    seed        = 32'h83ce;

    output_queue output_queue_inst (.*);

    always #10 axis_aclk = ~axis_aclk;

    task automatic abort_run(input string line);
        run_over = 1'b1;
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    //////////////////////////////
    // expected order
    //////////////////////////////

    // lowest rank first, the earlier arrival wins a tie
    function automatic id_list_t rank_order(input id_list_t ids);
        id_list_t left;
        id_list_t result;
        int       best;
        left = ids;
        while (left.size() > 0)
        begin
            best = 0;
            for (int i = 1; i < left.size(); i++)
            begin
                if (pkt_rank[left[i]] < pkt_rank[left[best]])
                begin
                    best = i;
                end
            end
            result.push_back(left[best]);
            left.delete(best);
        end
        return result;
    endfunction

    task automatic expect_in_rank_order(input id_list_t ids);
        id_list_t sorted;
        sorted = rank_order(ids);
        foreach (sorted[i])
        begin
            exp_order.push_back(sorted[i]);
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic new_packet(input int min_len, input int max_len, output int id);
        id = num_pkts;
        num_pkts++;
        pkt_len[id]  = min_len + int'($unsigned($random(seed)) % (max_len - min_len + 1));
        // four ranks only, so ties are common
        pkt_rank[id] = int'($unsigned($random(seed)) % 4) * 64;
        for (int w = 0; w < pkt_len[id]; w++)
        begin
            pkt_data[id][w] = {$random(seed), $random(seed)};
            pkt_keep[id][w] = {`OQ_KEEP_WIDTH{1'b1}};
        end
        pkt_keep[id][pkt_len[id] - 1] = {`OQ_KEEP_WIDTH{1'b1}} >> ($unsigned($random(seed)) % 8);
    endtask

    task automatic send_packet(input int id);
        for (int w = 0; w < pkt_len[id]; w++)
        begin
            @(posedge axis_aclk);
            s_axis_tvalid       <= 1'b1;
            s_axis_buffer_wr_en <= 1'b1;
            s_axis_tdata        <= pkt_data[id][w];
            s_axis_tkeep        <= pkt_keep[id][w];
            s_axis_tlast        <= (w == pkt_len[id] - 1);
            // junk in the address field, the queue must ignore it
            s_axis_tpifo        <= {`OQ_RANK_WIDTH'(pkt_rank[id]), `OQ_ADDR_WIDTH'(id + w)};
            words_in++;
        end
        @(posedge axis_aclk);
        s_axis_tvalid       <= 1'b0;
        s_axis_buffer_wr_en <= 1'b0;
        s_axis_tlast        <= 1'b0;
    endtask

    // into an empty queue, so the controller pops it alone
    task automatic send_lead_packet(input int min_len, input int max_len);
        int id;
        new_packet(min_len, max_len, id);
        exp_order.push_back(id);
        send_packet(id);
    endtask

    // stops early once either level rises
    task automatic send_burst(input int count, input int min_len, input int max_len);
        int id;
        burst.delete();
        for (int n = 0; n < count; n++)
        begin
            @(negedge axis_aclk);
            if (m_is_buffer_almost_full || m_is_pifo_full)
            begin
                break;
            end
            new_packet(min_len, max_len, id);
            send_packet(id);
            burst.push_back(id);
        end
    endtask

    task automatic drain(input bit random_ready);
        while (pkts_out < exp_order.size())
        begin
            @(posedge axis_aclk);
            if (random_ready)
            begin
                m_axis_tready <= ($random(seed) & 1) != 0;
            end
            else
            begin
                m_axis_tready <= 1'b1;
            end
        end
        @(posedge axis_aclk);
        m_axis_tready <= 1'b1;
        repeat (3) @(posedge axis_aclk);
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    // quiet queue, so the count is words in minus words out
    task automatic check_levels(input logic almost_full, input logic pifo_full);
        @(negedge axis_aclk);
        assert (m_is_buffer_almost_full == almost_full && m_is_pifo_full == pifo_full)
        else abort_run($sformatf("[ERROR] %0t: almost full %b pifo full %b, expected %b %b",
            $time, m_is_buffer_almost_full, m_is_pifo_full, almost_full, pifo_full));
        assert (int'(m_buffer_counter) == words_in - words_out)
        else abort_run($sformatf("[ERROR] %0t: buffer counter %0d, expected %0d",
            $time, m_buffer_counter, words_in - words_out));
    endtask

    task automatic check_word();
        int id;
        if (pkts_out >= exp_order.size())
        begin
            abort_run("an output word came out while no packet was expected");
        end
        else
        begin
            id = exp_order[pkts_out];
            assert (m_axis_tdata == pkt_data[id][word_idx])
            else abort_run($sformatf("[ERROR] %0t: packet %0d word %0d data %h, expected %h",
                $time, id, word_idx, m_axis_tdata, pkt_data[id][word_idx]));
            assert (m_axis_tkeep == pkt_keep[id][word_idx])
            else abort_run($sformatf("[ERROR] %0t: packet %0d word %0d keep %h, expected %h",
                $time, id, word_idx, m_axis_tkeep, pkt_keep[id][word_idx]));
            assert (m_axis_tlast == (word_idx == pkt_len[id] - 1))
            else abort_run($sformatf("[ERROR] %0t: packet %0d word %0d last %b, length %0d",
                $time, id, word_idx, m_axis_tlast, pkt_len[id]));
            assert (m_axis_tpifo[`OQ_PIFO_WIDTH-1 -: `OQ_RANK_WIDTH] == `OQ_RANK_WIDTH'(pkt_rank[id]))
            else abort_run($sformatf("[ERROR] %0t: packet %0d rank %0d, expected %0d",
                $time, id, m_axis_tpifo[`OQ_PIFO_WIDTH-1 -: `OQ_RANK_WIDTH], pkt_rank[id]));
            words_out++;
            if (word_idx == pkt_len[id] - 1)
            begin
                pkts_out++;
                word_idx = 0;
            end
            else
            begin
                word_idx++;
            end
        end
    endtask

    // outputs only change on the rising edge
    always @(negedge axis_aclk)
    begin
        if (axis_resetn && m_axis_tvalid && m_axis_tready)
        begin
            check_word();
        end
    end

    always @(posedge axis_aclk)
    begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        id_list_t tail;
        int       id;
        int       base;
        axis_resetn         = 1'b0;
        s_axis_tvalid       = 1'b0;
        s_axis_buffer_wr_en = 1'b0;
        s_axis_tdata        = '0;
        s_axis_tkeep        = '0;
        s_axis_tlast        = 1'b0;
        s_axis_tpifo        = '0;
        m_axis_tready       = 1'b1;
        repeat (16) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        repeat (2) @(posedge axis_aclk);

        // single packets through an empty queue
        for (int n = 0; n < 3; n++)
        begin
            new_packet(1, 8, id);
            exp_order.push_back(id);
            send_packet(id);
            drain(1'b0);
            check_levels(1'b0, 1'b0);
        end

        // short packets until the calendar fills, then drain with ready toggling
        @(posedge axis_aclk);
        m_axis_tready <= 1'b0;
        send_lead_packet(1, 8);
        send_burst(`OQ_PIFO_DEPTH, 1, 2);
        expect_in_rank_order(burst);
        check_levels(1'b0, 1'b1);
        drain(1'b1);
        check_levels(1'b0, 1'b0);

        // long packets until the buffer is almost full
        @(posedge axis_aclk);
        m_axis_tready <= 1'b0;
        send_lead_packet(6, 8);
        send_burst(8, 6, 8);
        expect_in_rank_order(burst);
        check_levels(1'b1, 1'b0);
        drain(1'b0);
        check_levels(1'b0, 1'b0);

        // new packets join while the third packet is held in the output
        base = pkts_out;
        @(posedge axis_aclk);
        m_axis_tready <= 1'b0;
        send_lead_packet(1, 4);
        send_burst(4, 1, 4);
        expect_in_rank_order(burst);
        @(posedge axis_aclk);
        m_axis_tready <= 1'b1;
        wait (pkts_out == base + 2);
        @(posedge axis_aclk);
        m_axis_tready <= 1'b0;
        send_burst(3, 1, 4);
        check_levels(1'b0, 1'b0);
        for (int i = base + 3; i < exp_order.size(); i++)
        begin
            tail.push_back(exp_order[i]);
        end
        while (exp_order.size() > base + 3)
        begin
            void'(exp_order.pop_back());
        end
        foreach (burst[i])
        begin
            tail.push_back(burst[i]);
        end
        expect_in_rank_order(tail);
        drain(1'b1);

        @(negedge axis_aclk);
        if (pkts_out == exp_order.size() && words_in == words_out && m_buffer_counter == '0)
        begin
            run_over = 1'b1;
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            abort_run("the run ended with packets or buffer words left over");
        end
    end

    // run stopped early by a bound assertion
    final
    begin
        if (!run_over)
        begin
            $display("*** FAILED ***");
        end
    end

endmodule

// ==== files.f ====
+incdir+include
src/oq_pkg.sv
src/pkt_store.sv
src/pifo_calendar.sv
src/dequeue_ctrl.sv
src/output_queue.sv
verif/output_queue_properties.sv
verif/output_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module output_queue_tb

./obj_dir/Voutput_queue_tb 2>&1 | tee sim.log

if grep -Fxq '*** PASSED ***' sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
